// File: build.f
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_icache_ifu.sv
verilog/fetch_inst_mem.sv
verilog/fetch_top.sv
verification/fetch_tb.sv

// File: verification/fetch_trace.txt
# records: load <byte addr> <word>, redirect <pc>, run, expect <pc> <inst>, test <name>
# values are hex; expect gives pc and instruction of the next accepted transfer
load 000 00100093
load 004 00200113
load 008 00300193
load 00c 00400213
load 010 00500293
load 014 00600313
load 200 10000517
load 204 00050593
load 208 00458613
load 20c 00c586b3
load 210 40d60733
load 214 00e787b3
load 044 00b00593
load 060 00c00613
load 064 00d00693
load 068 00e00713
load 06c 00f00793
run
expect 000 00100093
expect 004 00200113
expect 008 00300193
expect 00c 00400213
expect 010 00500293
expect 014 00600313
test sequential_fetch
redirect 200
expect 200 10000517
expect 204 00050593
expect 208 00458613
expect 20c 00c586b3
test burst_refill
load 20c 01c58e33
redirect 20c
run
expect 20c 00c586b3
expect 210 40d60733
test cached_line
load 040 0000100f
redirect 040
run
expect 040 0000100f
redirect 20c
expect 20c 01c58e33
test fence_i
redirect 000
expect 000 00100093
expect 004 00200113
expect 008 00300193
expect 00c 00400213
test back_pressure
redirect 064
expect 064 00d00693
expect 068 00e00713
expect 06c 00f00793
test high_word_redirect

// File: verification/fetch_tb.sv
module fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_EXPECT = 200;
  localparam string TRACE_FILE = "verification/fetch_trace.txt";

  logic                     clk;
  logic                     rst;
  logic                     run_i;
  logic                     redirect_i;
  logic [XLEN-1:0]          redirect_pc_i;
  logic                     ready_i;
  logic                     valid_o;
  logic [XLEN-1:0]          inst_o;
  logic [XLEN-1:0]          pc_o;
  logic                     load_we_i;
  logic [MEM_ADDR_BITS-1:0] load_addr_i;
  logic [XLEN-1:0]          load_data_i;

  // trace records in file order.
  string           rec_kind[$];
  logic [XLEN-1:0] rec_a[$];
  logic [XLEN-1:0] rec_b[$];
  string           rec_name[$];

  int error_count = 0;
  int test_errors = 0;
  int test_transfers = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int watchdog_cycles = 0;

  fetch_top DUT (
    .clk           (clk),
    .rst           (rst),
    .run_i         (run_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .ready_i       (ready_i),
    .valid_o       (valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // tokens read with %s sit right-justified with zero bytes in front.
  function automatic string bytes_to_string(input logic [8*32-1:0] w);
    string      s;
    logic [7:0] c;
    s = "";
    for (int i = 31; i >= 0; i--)
    begin
      c = w[8*i +: 8];
      if (c != 8'h00)
      begin
        s = $sformatf("%s%c", s, c);
      end
    end
    return s;
  endfunction

  task automatic count_error();
    error_count++;
    test_errors++;
  endtask

  task automatic read_trace();
    int              fd;
    int              n;
    int              ch;
    logic [8*32-1:0] word_w;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    string           kind;
    string           name;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0)
    begin
      $display("cannot open %s, so no stimulus was applied", TRACE_FILE);
      error_count++;
    end
    else
    begin
      word_w = '0;
      n = $fscanf(fd, "%s", word_w);
      while (n == 1)
      begin
        kind = bytes_to_string(word_w);
        a = '0;
        b = '0;
        name = "";
        word_w = '0;
        if (kind == "#")
        begin
          ch = $fgetc(fd); // a comment runs to the end of its line.
          while (ch != 10 && ch != -1)
          begin
            ch = $fgetc(fd);
          end
        end
        else
        begin
          if (kind == "load" || kind == "expect")
            n = $fscanf(fd, "%h %h", a, b);
          else if (kind == "redirect")
            n = $fscanf(fd, "%h", a);
          else if (kind == "test")
          begin
            n = $fscanf(fd, "%s", word_w);
            name = bytes_to_string(word_w);
          end
          rec_kind.push_back(kind);
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_name.push_back(name);
        end
        word_w = '0;
        n = $fscanf(fd, "%s", word_w);
      end
      $fclose(fd);
    end
  endtask

  task automatic load_word(input logic [XLEN-1:0] byte_addr, input logic [XLEN-1:0] data);
    @(posedge clk);
    run_i <= 1'b0;
    load_we_i <= 1'b1;
    load_addr_i <= byte_addr[MEM_ADDR_BITS+1:2];
    load_data_i <= data;
    @(posedge clk);
    load_we_i <= 1'b0;
  endtask

  task automatic redirect_to(input logic [XLEN-1:0] target);
    @(posedge clk);
    redirect_i <= 1'b1;
    redirect_pc_i <= target;
    @(posedge clk);
    redirect_i <= 1'b0;
  endtask

  task automatic raise_run();
    @(posedge clk);
    run_i <= 1'b1;
  endtask

  // Waits for the next transfer under random back-pressure. A stalled
  // instruction has to be offered again unchanged.
  task automatic expect_transfer(input logic [XLEN-1:0] exp_pc, input logic [XLEN-1:0] exp_inst);
    bit              done;
    bit              held;
    logic [XLEN-1:0] held_pc;
    logic [XLEN-1:0] held_inst;
    done = 1'b0;
    held = 1'b0;
    held_pc = '0;
    held_inst = '0;
    while (!done)
    begin
      @(posedge clk);
      ready_i <= ($urandom % 2) != 0;
      @(negedge clk);
      if (held)
      begin
        assert (valid_o === 1'b1 && pc_o === held_pc && inst_o === held_inst)
        else
        begin
          $display("error at %0d ns: stalled output moved to pc %h inst %h from pc %h inst %h",
                   $time, pc_o, inst_o, held_pc, held_inst);
          count_error();
        end
      end
      if (valid_o === 1'b1 && ready_i === 1'b1)
      begin
        assert (pc_o === exp_pc)
        else
        begin
          $display("error at %0d ns: pc %h, expected %h", $time, pc_o, exp_pc);
          count_error();
        end
        assert (inst_o === exp_inst)
        else
        begin
          $display("error at %0d ns: inst %h at pc %h, expected %h", $time, inst_o, pc_o, exp_inst);
          count_error();
        end
        test_transfers++;
        done = 1'b1;
      end
      else
      begin
        held = (valid_o === 1'b1);
        held_pc = pc_o;
        held_inst = inst_o;
      end
    end
    @(posedge clk); // the transfer happens on this edge.
    ready_i <= 1'b0;
  endtask

  task automatic close_test(input string name);
    if (test_errors == 0)
    begin
      $display("test %s: passed, %0d transfers checked", name, test_transfers);
      tests_passed++;
    end
    else
    begin
      $display("test %s: failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
    test_transfers = 0;
  endtask

  initial
  begin
    int expects;
    rst = 1'b1;
    run_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    ready_i = 1'b0;
    load_we_i = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    void'($urandom(12));
    read_trace();
    expects = 0;
    foreach (rec_kind[i])
    begin
      if (rec_kind[i] == "expect")
        expects++;
    end
    watchdog_cycles = 2 * RESET_CYCLES + CYCLES_PER_EXPECT * expects + 4 * rec_kind.size();
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    foreach (rec_kind[i])
    begin
      if (rec_kind[i] == "load")
        load_word(rec_a[i], rec_b[i]);
      else if (rec_kind[i] == "redirect")
        redirect_to(rec_a[i]);
      else if (rec_kind[i] == "run")
        raise_run();
      else if (rec_kind[i] == "expect")
        expect_transfer(rec_a[i], rec_b[i]);
      else if (rec_kind[i] == "test")
        close_test(rec_name[i]);
      else
      begin
        $display("the trace holds an unknown record kind %s", rec_kind[i]);
        error_count++;
      end
    end
    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0 && tests_passed > 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the DUT stopped delivering instructions",
             watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: verilog/fetch_top.sv
module fetch_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                run_i,
  input  logic                                redirect_i,
  input  logic [fetch_pkg::XLEN-1:0]          redirect_pc_i,
  input  logic                                ready_i,
  output logic                                valid_o,
  output logic [fetch_pkg::XLEN-1:0]          inst_o,
  output logic [fetch_pkg::XLEN-1:0]          pc_o,
  input  logic                                load_we_i,
  input  logic [fetch_pkg::MEM_ADDR_BITS-1:0] load_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]          load_data_i
);
  import fetch_pkg::*;

  logic [XLEN-1:0] fetch_pc;
  logic            fetch_req;
  logic            accept;

  // read bus between the fetch unit and the memory.
  logic [XLEN-1:0] araddr;
  logic            arvalid;
  logic            arlen;
  logic [XLEN-1:0] rdata;
  logic            rvalid;

  fetch_pc_gen u_pc_gen (
    .clk           (clk),
    .rst           (rst),
    .run_i         (run_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .accept_i      (accept),
    .pc_o          (fetch_pc),
    .req_o         (fetch_req)
  );

  fetch_icache_ifu u_ifu (
    .clk       (clk),
    .rst       (rst),
    .pc_i      (fetch_pc),
    .req_i     (fetch_req),
    .ready_i   (ready_i),
    .valid_o   (valid_o),
    .inst_o    (inst_o),
    .pc_o      (pc_o),
    .accept_o  (accept),
    .araddr_o  (araddr),
    .arvalid_o (arvalid),
    .arlen_o   (arlen),
    .rdata_i   (rdata),
    .rvalid_i  (rvalid)
  );

  fetch_inst_mem u_mem (
    .clk         (clk),
    .rst         (rst),
    .araddr_i    (araddr),
    .arvalid_i   (arvalid),
    .arlen_i     (arlen),
    .rdata_o     (rdata),
    .rvalid_o    (rvalid),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

endmodule

// File: verilog/fetch_inst_mem.sv
module fetch_inst_mem (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [fetch_pkg::XLEN-1:0]          araddr_i,
  input  logic                                arvalid_i,
  input  logic                                arlen_i,
  output logic [fetch_pkg::XLEN-1:0]          rdata_o,
  output logic                                rvalid_o,
  input  logic                                load_we_i,
  input  logic [fetch_pkg::MEM_ADDR_BITS-1:0] load_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]          load_data_i
);
  import fetch_pkg::*;

  logic [XLEN-1:0] mem [MEM_WORDS];

  mem_state_e              state_q;
  logic [LAT_BITS-1:0]     wait_cnt_q;
  logic                    burst_q; // a second beat is still owed.
  logic [MEM_ADDR_BITS-1:0] rd_addr_q;
  logic [XLEN-1:0]         rdata_q;

  logic accept_req;
  logic wait_done;
  logic fetch_word;

  assign accept_req = arvalid_i && (state_q == MEM_IDLE);
  assign wait_done = (wait_cnt_q == LAT_BITS'(MEM_LATENCY - 2));

  // the array is read one cycle ahead of each beat.
  assign fetch_word = ((state_q == MEM_WAIT) && wait_done) ||
                      ((state_q == MEM_BEAT) && burst_q);

  assign rvalid_o = (state_q == MEM_BEAT);
  assign rdata_o = rdata_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= MEM_IDLE;
      wait_cnt_q <= '0;
      burst_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        MEM_IDLE:
        begin
          if (arvalid_i)
          begin
            state_q <= MEM_WAIT;
            wait_cnt_q <= '0;
            burst_q <= arlen_i;
          end
        end
        MEM_WAIT:
        begin
          if (wait_done)
          begin
            state_q <= MEM_BEAT;
          end
          else
          begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
          end
        end
        MEM_BEAT:
        begin
          if (burst_q)
          begin
            burst_q <= 1'b0; // stay one more cycle for the high word.
          end
          else
          begin
            state_q <= MEM_IDLE;
          end
        end
        default:
        begin
          state_q <= MEM_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept_req)
    begin
      rd_addr_q <= araddr_i[MEM_ADDR_BITS+1:2];
    end
    else if (fetch_word)
    begin
      rdata_q <= mem[rd_addr_q];
      rd_addr_q <= rd_addr_q + 1'b1;
    end
    if (load_we_i)
    begin
      mem[load_addr_i] <= load_data_i;
    end
  end

  // the master must hold off until the previous request has finished.
  a_req_when_idle : assert property (
    @(posedge clk) disable iff (rst)
    arvalid_i |-> (state_q == MEM_IDLE)
  );

endmodule

// File: verilog/fetch_icache_ifu.sv
module fetch_icache_ifu (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  logic                       req_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output logic [fetch_pkg::XLEN-1:0] inst_o,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic                       accept_o,
  output logic [fetch_pkg::XLEN-1:0] araddr_o,
  output logic                       arvalid_o,
  output logic                       arlen_o,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  logic                       rvalid_i
);
  import fetch_pkg::*;

  // cache arrays.
  logic [XLEN-1:0]        line_mem [ICACHE_SETS][LINE_WORDS];
  logic [TAG_BITS-1:0]    tag_mem [ICACHE_SETS];
  logic [ICACHE_SETS-1:0] line_valid_q;

  // refill control and payload.
  refill_state_e   state_q;
  logic            hi_issue_q;
  logic [XLEN-1:0] fill_addr_q;
  logic            fill_burst_q;
  logic [XLEN-1:0] lo_word_q;

  logic [TAG_BITS-1:0]    pc_tag;
  logic [SET_BITS-1:0]    pc_index;
  logic [OFFSET_BITS-1:0] pc_offset;
  logic [SET_BITS-1:0]    fill_index;
  logic [XLEN-1:0]        line_base;
  logic                   in_burst;
  logic                   lookup;
  logic                   tag_match;
  logic                   hit;
  logic                   miss;
  logic                   fence_seen;

  assign pc_tag = pc_i[XLEN-1:TAG_LSB];
  assign pc_index = pc_i[TAG_LSB-1:INDEX_LSB];
  assign pc_offset = pc_i[INDEX_LSB-1:OFFSET_LSB];
  assign line_base = {pc_i[XLEN-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
  assign fill_index = fill_addr_q[TAG_LSB-1:INDEX_LSB];

  assign in_burst = (line_base >= BURST_BASE) && (line_base <= BURST_LIMIT);

  // Lookups happen only while no refill is running.
  assign lookup = req_i && (state_q == IDLE);
  assign tag_match = line_valid_q[pc_index] && (tag_mem[pc_index] == pc_tag);
  assign hit = lookup && tag_match;
  assign miss = lookup && !tag_match;

  assign valid_o = hit;
  assign inst_o = line_mem[pc_index][pc_offset];
  assign pc_o = pc_i;
  assign accept_o = hit && ready_i;
  assign fence_seen = accept_o && (inst_o == FENCE_I_INST);

  // the low word (or the whole burst) is requested in the cycle the miss is
  // seen. The high word goes out on the first cycle of WAIT_HIGH.
  assign arvalid_o = miss || hi_issue_q;
  assign araddr_o = hi_issue_q ? (fill_addr_q + XLEN'(4)) : line_base;
  assign arlen_o = miss && in_burst;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= IDLE;
      hi_issue_q <= 1'b0;
      line_valid_q <= '0;
    end
    else
    begin
      hi_issue_q <= 1'b0;
      if (fence_seen)
      begin
        line_valid_q <= '0; // every line goes stale after FENCE.I.
      end
      case (state_q)
        IDLE:
        begin
          if (miss)
          begin
            state_q <= REQ_LOW;
          end
        end
        REQ_LOW:
        begin
          if (rvalid_i)
          begin
            state_q <= fill_burst_q ? WAIT_HIGH : GAP;
          end
        end
        GAP:
        begin
          state_q <= WAIT_HIGH;
          hi_issue_q <= 1'b1;
        end
        WAIT_HIGH:
        begin
          if (rvalid_i)
          begin
            state_q <= IDLE;
            line_valid_q[fill_index] <= 1'b1; // line usable from the next cycle.
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // The refill works on the latched line address, so a redirect during a
  // refill still completes the line that missed.
  always_ff @(posedge clk)
  begin
    if (miss)
    begin
      fill_addr_q <= line_base;
      fill_burst_q <= in_burst;
    end
    if ((state_q == REQ_LOW) && rvalid_i)
    begin
      lo_word_q <= rdata_i;
    end
    if ((state_q == WAIT_HIGH) && rvalid_i)
    begin
      line_mem[fill_index][0] <= lo_word_q;
      line_mem[fill_index][1] <= rdata_i;
      tag_mem[fill_index] <= fill_addr_q[XLEN-1:TAG_LSB];
    end
  end

  // after a request no new one goes out before the memory returns a beat.
  a_one_outstanding : assert property (
    @(posedge clk) disable iff (rst)
    arvalid_o |=> (!arvalid_o throughout rvalid_i[->1])
  );

  // read data only arrives while a refill is waiting for it.
  a_no_rvalid_idle : assert property (
    @(posedge clk) disable iff (rst)
    rvalid_i |-> (state_q != IDLE) && (state_q != GAP)
  );

endmodule

// File: verilog/fetch_pc_gen.sv
module fetch_pc_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run_i,
  input  logic                       redirect_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                       accept_i,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic                       req_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic            req_q;

  assign pc_o = pc_q;
  assign req_o = req_q;

  // A redirect wins over advancing. Either event lowers the request for one
  // cycle so the fetch unit sees the new pc before it looks up again.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
      req_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      pc_q <= redirect_pc_i;
      req_q <= 1'b0;
    end
    else if (accept_i)
    begin
      pc_q <= pc_q + XLEN'(4);
      req_q <= 1'b0;
    end
    else
    begin
      req_q <= run_i; // follows run once the pc is settled.
    end
  end

  // instructions are word aligned, so every target must be too.
  a_redirect_aligned : assert property (
    @(posedge clk) disable iff (rst)
    redirect_i |-> (redirect_pc_i[1:0] == 2'b00)
  );

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

  localparam int XLEN = 32;

  // direct-mapped cache of four sets with two-word lines.
  localparam int ICACHE_SETS = 4;
  localparam int SET_BITS = 2;
  localparam int LINE_WORDS = 2;
  localparam int OFFSET_BITS = 1;
  localparam int TAG_BITS = XLEN - SET_BITS - OFFSET_BITS - 2;

  // the word offset sits at pc bit 2, the index at 4..3 and the tag at 31..5.
  localparam int OFFSET_LSB = 2;
  localparam int INDEX_LSB = OFFSET_LSB + OFFSET_BITS;
  localparam int TAG_LSB = INDEX_LSB + SET_BITS;

  localparam int MEM_WORDS = 256;
  localparam int MEM_ADDR_BITS = 8;

  // lines inside this byte window are refilled with one two-beat burst.
  localparam logic [XLEN-1:0] BURST_BASE = 32'h0000_0200;
  localparam logic [XLEN-1:0] BURST_LIMIT = 32'h0000_03FF;

  localparam int MEM_LATENCY = 3; // cycles from accepted request to first beat.
  localparam int LAT_BITS = 2;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [XLEN-1:0] FENCE_I_INST = 32'h0000_100F;

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    REQ_LOW = 2'b01,
    GAP = 2'b10,
    WAIT_HIGH = 2'b11
  } refill_state_e;

  typedef enum logic [1:0] {
    MEM_IDLE = 2'b00,
    MEM_WAIT = 2'b01,
    MEM_BEAT = 2'b10
  } mem_state_e;

endpackage
